// ==== Bender.yml ====
package:
  name: dsi_packet_assembler

sources:
  - rtl/dsi_proto_pkg.sv
  - rtl/dsi_lane_pkg.sv
  - rtl/packet_framer.sv
  - rtl/crc_inserter.sv
  - rtl/lane_repacker.sv
  - rtl/dsi_packet_assembler.sv
  - target: test
    files:
      - test/dsi_assembler_props.sv
      - test/tb_dsi_packet_assembler.sv

// ==== compile.f ====
rtl/dsi_proto_pkg.sv
rtl/dsi_lane_pkg.sv
rtl/packet_framer.sv
rtl/crc_inserter.sv
rtl/lane_repacker.sv
rtl/dsi_packet_assembler.sv
test/dsi_assembler_props.sv
test/tb_dsi_packet_assembler.sv

// ==== rtl/crc_inserter.sv ====
`timescale 1ns/1ps

module crc_inserter (
    input  logic                      clk,
    input  logic                      rst_n,
    input  dsi_proto_pkg::word_t      f_data,
    input  dsi_lane_pkg::byte_count_t f_bytes,
    input  dsi_proto_pkg::beat_kind_t f_kind,
    input  logic                      f_last,
    input  logic                      f_valid,
    input  logic                      c_ready,
    output logic                      f_ready,
    output dsi_proto_pkg::word_t      c_data,
    output dsi_lane_pkg::byte_count_t c_bytes,
    output dsi_proto_pkg::beat_kind_t c_kind,
    output logic                      c_last,
    output logic                      c_valid
);
    import dsi_proto_pkg::*;

    crc_t crc_q;     // running crc of the current packet
    crc_t crc_fold;  // crc_q with this beat's bytes folded in
    logic take;

    // one byte, lsb first
    function automatic crc_t crc_step(input crc_t crc, input byte_t data);
        crc_t c;
        c = crc ^ {8'h00, data};
        for (int b = 0; b < 8; b++)
            c = c[0] ? ((c >> 1) ^ CRC_POLY_REFLECTED) : (c >> 1);
        return c;
    endfunction

    assign f_ready = !c_valid || c_ready;
    assign take    = f_valid && f_ready;

    always_comb
    begin
        crc_fold = crc_q;
        for (int i = 0; i < $bits(word_t) / 8; i++)
        begin
            if (i < int'(f_bytes))
                crc_fold = crc_step(crc_fold, f_data[8*i +: 8]);  // byte 0 first
        end
    end

    always_ff @(posedge clk)
    begin
        if (take && f_kind == KIND_HEADER)
            crc_q <= CRC_INIT;
        else if (take && f_kind == KIND_PAYLOAD)
            crc_q <= crc_fold;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            c_valid <= 1'b0;
        else if (f_ready)
            c_valid <= f_valid;
    end

    always_ff @(posedge clk)
    begin
        if (take)
        begin
            c_data  <= (f_kind == KIND_CRC) ? word_t'({16'h0000, crc_q}) : f_data;  // low byte first
            c_bytes <= f_bytes;
            c_kind  <= f_kind;
            c_last  <= f_last;
        end
    end

endmodule

// ==== rtl/dsi_lane_pkg.sv ====
package dsi_lane_pkg;

    localparam int MAX_LANES = 4;

    // lanes in use, 1 to MAX_LANES
    typedef logic [2:0] lane_count_t;

    // valid bytes in a beat, 1 to 4
    typedef logic [2:0] byte_count_t;

    typedef logic [MAX_LANES-1:0]   lane_mask_t;  // one bit per lane
    typedef logic [8*MAX_LANES-1:0] lane_data_t;  // lane i in byte i

endpackage

// ==== rtl/dsi_packet_assembler.sv ====
`timescale 1ns/1ps

module dsi_packet_assembler (
    input  logic                      clk,
    input  logic                      rst_n,
    input  dsi_proto_pkg::word_t      in_data,
    input  logic                      in_valid,
    input  dsi_lane_pkg::lane_count_t lane_count,
    input  logic                      lane_ready,
    output logic                      in_ready,
    output dsi_lane_pkg::lane_data_t  lane_data,
    output dsi_lane_pkg::lane_mask_t  lane_valid,
    output logic                      lane_last
);
    import dsi_proto_pkg::*;
    import dsi_lane_pkg::*;

    // framer to crc stage
    word_t       f_data;
    byte_count_t f_bytes;
    beat_kind_t  f_kind;
    logic        f_last;
    logic        f_valid;
    logic        f_ready;

    // crc stage to repacker
    word_t       c_data;
    byte_count_t c_bytes;
    logic        c_last;
    logic        c_valid;
    logic        c_ready;

    packet_framer u_framer (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_data  (in_data),
        .in_valid (in_valid),
        .f_ready  (f_ready),
        .in_ready (in_ready),
        .f_data   (f_data),
        .f_bytes  (f_bytes),
        .f_kind   (f_kind),
        .f_last   (f_last),
        .f_valid  (f_valid)
    );

    crc_inserter u_crc (
        .clk     (clk),
        .rst_n   (rst_n),
        .f_data  (f_data),
        .f_bytes (f_bytes),
        .f_kind  (f_kind),
        .f_last  (f_last),
        .f_valid (f_valid),
        .c_ready (c_ready),
        .f_ready (f_ready),
        .c_data  (c_data),
        .c_bytes (c_bytes),
        .c_kind  (),  // repacker works on bytes only
        .c_last  (c_last),
        .c_valid (c_valid)
    );

    lane_repacker u_repacker (
        .clk        (clk),
        .rst_n      (rst_n),
        .c_data     (c_data),
        .c_bytes    (c_bytes),
        .c_last     (c_last),
        .c_valid    (c_valid),
        .lane_count (lane_count),
        .lane_ready (lane_ready),
        .c_ready    (c_ready),
        .lane_data  (lane_data),
        .lane_valid (lane_valid),
        .lane_last  (lane_last)
    );

endmodule

// ==== rtl/dsi_proto_pkg.sv ====
package dsi_proto_pkg;

    typedef logic [31:0] word_t;        // stream word, byte 0 first on the wire
    typedef logic [7:0]  byte_t;
    typedef logic [15:0] word_count_t;  // payload length in bytes
    typedef logic [7:0]  data_id_t;     // vc in 7:6, type in 5:0
    typedef logic [5:0]  data_type_t;
    typedef logic [15:0] crc_t;
    typedef logic [7:0]  ecc_t;         // bits 7:6 always zero

    typedef enum logic [1:0]
    {
        KIND_HEADER,
        KIND_PAYLOAD,
        KIND_CRC
    } beat_kind_t;

    localparam data_type_t DT_BLANKING     = 6'h19;
    localparam data_type_t DT_GENERIC_LONG = 6'h29;
    localparam data_type_t DT_DCS_LONG     = 6'h39;
    localparam data_type_t DT_PPS24        = 6'h3E;

    localparam crc_t CRC_INIT           = 16'hFFFF;
    localparam crc_t CRC_POLY_REFLECTED = 16'h8408;  // x^16+x^12+x^5+1, lsb first

    localparam int HEADER_BYTES = 4;
    localparam int CRC_BYTES    = 2;

    function automatic logic is_long_type(input data_type_t dt);
        return dt inside {DT_BLANKING, DT_GENERIC_LONG, DT_DCS_LONG, DT_PPS24};
    endfunction

    // bits are {wc msb, wc lsb, data id}, data id in 7:0
    function automatic ecc_t header_ecc(input logic [23:0] d);
        ecc_t ecc;
        ecc    = '0;
        ecc[0] = ^(d & 24'hF12CB7);
        ecc[1] = ^(d & 24'hF2555B);
        ecc[2] = ^(d & 24'h749A6D);
        ecc[3] = ^(d & 24'hB8E38E);
        ecc[4] = ^(d & 24'hDF03F0);
        ecc[5] = ^(d & 24'hEFFC00);
        return ecc;
    endfunction

endpackage

// ==== rtl/lane_repacker.sv ====
`timescale 1ns/1ps

module lane_repacker (
    input  logic                      clk,
    input  logic                      rst_n,
    input  dsi_proto_pkg::word_t      c_data,
    input  dsi_lane_pkg::byte_count_t c_bytes,
    input  logic                      c_last,
    input  logic                      c_valid,
    input  dsi_lane_pkg::lane_count_t lane_count,
    input  logic                      lane_ready,
    output logic                      c_ready,
    output dsi_lane_pkg::lane_data_t  lane_data,
    output dsi_lane_pkg::lane_mask_t  lane_valid,
    output logic                      lane_last
);
    import dsi_proto_pkg::*;
    import dsi_lane_pkg::*;

    byte_t       sb_q  [2*MAX_LANES-1];  // shadow buffer, byte 0 oldest
    byte_t       sb_d  [2*MAX_LANES-1];
    byte_t       avail [2*MAX_LANES-1];  // buffer plus the beat taken now
    logic [2:0]  cnt_q;
    logic [3:0]  avail_cnt;
    logic        last_q;                 // buffer holds the end of a packet
    logic        avail_last;
    logic        acc;
    logic        out_free;
    logic        issue;
    lane_count_t lanes;
    byte_count_t take;
    lane_mask_t  take_mask;
    lane_data_t  beat_data;

    // room for a full word, and never mix two packets
    assign c_ready  = (cnt_q < 3'(MAX_LANES)) && !last_q;
    assign acc      = c_valid && c_ready;
    assign out_free = (lane_valid == '0) || lane_ready;

    always_comb
    begin
        if (lane_count == '0)
            lanes = lane_count_t'(1);
        else if (lane_count > lane_count_t'(MAX_LANES))
            lanes = lane_count_t'(MAX_LANES);
        else
            lanes = lane_count;
    end

    assign avail_cnt  = {1'b0, cnt_q} + (acc ? {1'b0, c_bytes} : 4'd0);
    assign avail_last = last_q || (acc && c_last);
    assign issue      = out_free && (avail_cnt != '0) &&
                        ((avail_cnt >= {1'b0, lanes}) || avail_last);
    assign take       = !issue ? '0 :
                        (avail_cnt >= {1'b0, lanes}) ? lanes : avail_cnt[2:0];  // partial tail

    always_comb
    begin : merge_blk
        int pos;
        for (int i = 0; i < 2*MAX_LANES-1; i++)
        begin
            pos = i - int'(cnt_q);
            if (pos < 0)
                avail[i] = sb_q[i];
            else if (pos < MAX_LANES)
                avail[i] = c_data[8*pos +: 8];  // new bytes go behind the old
            else
                avail[i] = '0;
        end
    end

    always_comb
    begin : shift_blk
        int src;
        for (int i = 0; i < 2*MAX_LANES-1; i++)
        begin
            src = i + int'(take);
            if (src < 2*MAX_LANES-1)
                sb_d[i] = avail[src];
            else
                sb_d[i] = '0;
        end
        for (int i = 0; i < MAX_LANES; i++)
        begin
            take_mask[i]        = (i < int'(take));
            beat_data[8*i +: 8] = take_mask[i] ? avail[i] : '0;  // idle lanes read zero
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            cnt_q      <= '0;
            last_q     <= 1'b0;
            lane_valid <= '0;
            lane_last  <= 1'b0;
        end
        else
        begin
            cnt_q  <= 3'(avail_cnt - {1'b0, take});
            last_q <= avail_last && (avail_cnt != {1'b0, take});
            if (out_free)
            begin
                lane_valid <= take_mask;
                lane_last  <= issue && avail_last && (avail_cnt == {1'b0, take});
            end
        end
    end

    always_ff @(posedge clk)
    begin
        sb_q <= sb_d;
        if (out_free)
            lane_data <= beat_data;
    end

endmodule

// ==== rtl/packet_framer.sv ====
`timescale 1ns/1ps

module packet_framer (
    input  logic                      clk,
    input  logic                      rst_n,
    input  dsi_proto_pkg::word_t      in_data,
    input  logic                      in_valid,
    input  logic                      f_ready,
    output logic                      in_ready,
    output dsi_proto_pkg::word_t      f_data,
    output dsi_lane_pkg::byte_count_t f_bytes,
    output dsi_proto_pkg::beat_kind_t f_kind,
    output logic                      f_last,
    output logic                      f_valid
);
    import dsi_proto_pkg::*;
    import dsi_lane_pkg::*;

    typedef enum logic [1:0]
    {
        HEADER,
        PAYLOAD,
        CRC_SLOT
    } state_t;

    state_t      state_q;
    word_count_t remain_q;     // payload bytes still to come
    logic        running_q;    // low for the first cycle out of reset
    logic        out_free;
    logic        take_in;
    logic        emit;
    logic        hdr_long;
    data_id_t    hdr_id;
    word_count_t hdr_wc;
    byte_count_t pay_bytes;

    assign hdr_id   = in_data[23:16];
    assign hdr_wc   = in_data[15:0];  // short types carry data bytes here
    assign hdr_long = is_long_type(hdr_id[5:0]);

    assign out_free = !f_valid || f_ready;
    assign in_ready = running_q && out_free && (state_q != CRC_SLOT);
    assign take_in  = in_valid && in_ready;
    assign emit     = take_in || (out_free && state_q == CRC_SLOT);

    // partial last word
    assign pay_bytes = (remain_q > 16'd4) ? 3'd4 : remain_q[2:0];

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state_q   <= HEADER;
            remain_q  <= '0;
            running_q <= 1'b0;
        end
        else
        begin
            running_q <= 1'b1;
            case (state_q)
                HEADER:
                    if (take_in && hdr_long)
                    begin
                        remain_q <= hdr_wc;
                        state_q  <= (hdr_wc == '0) ? CRC_SLOT : PAYLOAD;  // empty payload
                    end
                PAYLOAD:
                    if (take_in)
                    begin
                        remain_q <= remain_q - word_count_t'(pay_bytes);
                        if (remain_q <= 16'd4)
                            state_q <= CRC_SLOT;
                    end
                CRC_SLOT:
                    if (emit)
                        state_q <= HEADER;
                default:
                    state_q <= HEADER;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            f_valid <= 1'b0;
        else if (out_free)
            f_valid <= emit;
    end

    always_ff @(posedge clk)
    begin
        if (emit)
        begin
            case (state_q)
                HEADER:
                begin
                    f_data  <= {header_ecc({hdr_wc, hdr_id}), hdr_wc[15:8], hdr_wc[7:0], hdr_id};
                    f_bytes <= byte_count_t'(HEADER_BYTES);
                    f_kind  <= KIND_HEADER;
                    f_last  <= !hdr_long;  // short packet ends here
                end
                PAYLOAD:
                begin
                    f_data  <= in_data;
                    f_bytes <= pay_bytes;
                    f_kind  <= KIND_PAYLOAD;
                    f_last  <= 1'b0;
                end
                default:
                begin
                    f_data  <= '0;  // filled in by the crc stage
                    f_bytes <= byte_count_t'(CRC_BYTES);
                    f_kind  <= KIND_CRC;
                    f_last  <= 1'b1;
                end
            endcase
        end
    end

endmodule

// ==== test/dsi_assembler_props.sv ====
`timescale 1ns/1ps

module dsi_assembler_props (
    input logic                      clk,
    input logic                      rst_n,
    input dsi_lane_pkg::lane_count_t lane_count,
    input logic                      lane_ready,
    input dsi_lane_pkg::lane_data_t  lane_data,
    input dsi_lane_pkg::lane_mask_t  lane_valid,
    input logic                      lane_last
);
    import dsi_lane_pkg::*;

    int fail_count;  // failed assertions so far

    // a waiting beat stays put until the sink takes it
    hold_while_stalled: assert property (@(posedge clk) disable iff (!rst_n)
        (lane_valid != '0 && !lane_ready) |=>
        ($stable(lane_valid) && $stable(lane_data) && $stable(lane_last)))
    else
    begin
        $error("lane beat changed while lane_ready was low");
        fail_count++;
    end

    mask_contiguous: assert property (@(posedge clk) disable iff (!rst_n)
        lane_valid inside {4'b0000, 4'b0001, 4'b0011, 4'b0111, 4'b1111})
    else
    begin
        $error("lane_valid mask %b has a gap", lane_valid);
        fail_count++;
    end

    full_beat_width: assert property (@(posedge clk) disable iff (!rst_n)
        (lane_valid != '0 && !lane_last) |-> ($countones(lane_valid) == int'(lane_count)))
    else
    begin
        $error("non-last beat mask %b does not match lane_count %0d", lane_valid, lane_count);
        fail_count++;
    end

endmodule

bind dsi_packet_assembler dsi_assembler_props u_props (
    .clk        (clk),
    .rst_n      (rst_n),
    .lane_count (lane_count),
    .lane_ready (lane_ready),
    .lane_data  (lane_data),
    .lane_valid (lane_valid),
    .lane_last  (lane_last)
);

// ==== test/tb_dsi_packet_assembler.sv ====
`timescale 1ns/1ps

module tb_dsi_packet_assembler;
    import dsi_proto_pkg::*;
    import dsi_lane_pkg::*;

    localparam int NUM_TESTS      = 6;
    localparam int TIMEOUT_CYCLES = 200;

    typedef struct
    {
        string       name;
        data_id_t    id;
        logic [15:0] wc_or_data;  // word count or the two data bytes of a short packet
        lane_count_t lanes;
        bit          gaps;        // random idle cycles on in_valid
        bit          stalls;      // random low lane_ready
    } test_row_t;

    logic        clk;
    logic        rst_n;
    word_t       in_data;
    logic        in_valid;
    lane_count_t lane_count;
    logic        lane_ready;
    logic        in_ready;
    lane_data_t  lane_data;
    lane_mask_t  lane_valid;
    logic        lane_last;

    test_row_t   tests [NUM_TESTS];
    integer      seed;
    int          errors;
    int          timeouts;
    byte_t       exp_bytes [$];      // expected byte stream of the current packet
    word_t       words [$];          // input words of the current packet
    int          idle_cycles [$];
    bit          ready_pattern [$];

    dsi_packet_assembler DUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_data    (in_data),
        .in_valid   (in_valid),
        .lane_count (lane_count),
        .lane_ready (lane_ready),
        .in_ready   (in_ready),
        .lane_data  (lane_data),
        .lane_valid (lane_valid),
        .lane_last  (lane_last)
    );

    always #4 clk = ~clk;

    function automatic bit is_long_id(input data_id_t id);
        return id[5:0] == DT_BLANKING || id[5:0] == DT_GENERIC_LONG ||
               id[5:0] == DT_DCS_LONG || id[5:0] == DT_PPS24;
    endfunction

    // parity equations of the DSI header code with the data id in d[7:0]
    function automatic ecc_t header_parity(input logic [23:0] d);
        ecc_t p;
        p    = '0;
        p[0] = d[0]^d[1]^d[2]^d[4]^d[5]^d[7]^d[10]^d[11]^d[13]^d[16]^d[20]^d[21]^d[22]^d[23];
        p[1] = d[0]^d[1]^d[3]^d[4]^d[6]^d[8]^d[10]^d[12]^d[14]^d[17]^d[20]^d[21]^d[22]^d[23];
        p[2] = d[0]^d[2]^d[3]^d[5]^d[6]^d[9]^d[11]^d[12]^d[15]^d[18]^d[20]^d[21]^d[22];
        p[3] = d[1]^d[2]^d[3]^d[7]^d[8]^d[9]^d[13]^d[14]^d[15]^d[19]^d[20]^d[21]^d[23];
        p[4] = d[4]^d[5]^d[6]^d[7]^d[8]^d[9]^d[16]^d[17]^d[18]^d[19]^d[20]^d[22]^d[23];
        p[5] = d[10]^d[11]^d[12]^d[13]^d[14]^d[15]^d[16]^d[17]^d[18]^d[19]^d[21]^d[22]^d[23];
        return p;
    endfunction

    function automatic crc_t payload_crc(input byte_t data [$]);
        crc_t crc;
        logic fb;
        crc = CRC_INIT;
        foreach (data[k])
            for (int b = 0; b < 8; b++)
            begin
                fb  = crc[0] ^ data[k][b];  // lsb of each byte first
                crc = crc >> 1;
                if (fb)
                    crc = crc ^ CRC_POLY_REFLECTED;
            end
        return crc;
    endfunction

    function automatic void build_packet(input test_row_t t);
        byte_t payload [$];
        word_t w;
        crc_t  crc;
        int    nwords;
        exp_bytes.delete();
        words.delete();
        idle_cycles.delete();
        ready_pattern.delete();
        seed = 32'h852e;  // equal word counts give equal payloads
        words.push_back({8'hA7, t.id, t.wc_or_data});  // top byte is ignored
        exp_bytes.push_back(t.id);
        exp_bytes.push_back(t.wc_or_data[7:0]);
        exp_bytes.push_back(t.wc_or_data[15:8]);
        exp_bytes.push_back(header_parity({t.wc_or_data, t.id}));
        if (is_long_id(t.id))
        begin
            nwords = (int'(t.wc_or_data) + 3) / 4;
            for (int k = 0; k < nwords; k++)
            begin
                w = $random(seed);
                words.push_back(w);
                for (int i = 0; i < 4; i++)
                    if (4*k + i < int'(t.wc_or_data))
                        payload.push_back(w[8*i +: 8]);  // tail bytes of the last word dropped
            end
            crc = payload_crc(payload);
            foreach (payload[k])
                exp_bytes.push_back(payload[k]);
            exp_bytes.push_back(crc[7:0]);
            exp_bytes.push_back(crc[15:8]);
        end
        foreach (words[k])
            idle_cycles.push_back(t.gaps ? $unsigned($random(seed)) % 4 : 0);
        for (int k = 0; k < 64; k++)
            ready_pattern.push_back(t.stalls ? ($random(seed) % 2 != 0) : 1'b1);
    endfunction

    function automatic void check_value(input string name, input string what,
                                        input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp)
        else
        begin
            $display("** Error: test %s, %s expected %h actual %h", name, what, exp, act);
            errors++;
        end
    endfunction

    task automatic drive_words(input string name);
        int waited;
        for (int k = 0; k < words.size(); k++)
        begin
            repeat (idle_cycles[k])
            begin
                in_valid <= 1'b0;
                @(posedge clk);
            end
            in_data  <= words[k];
            in_valid <= 1'b1;
            waited   = 0;
            @(posedge clk);
            while (!in_ready && waited < TIMEOUT_CYCLES)
            begin
                @(posedge clk);
                waited++;
            end
            if (!in_ready)
            begin
                $display("Timeout in test %s: input word %0d was never accepted", name, k);
                timeouts++;
            end
        end
        in_valid <= 1'b0;
    endtask

    task automatic collect_beats(input string name, input int lanes);
        int         pos;
        int         cnt;
        int         waited;
        int         cycle;
        lane_mask_t exp_mask;
        lane_data_t exp_data;
        lane_data_t keep;
        pos    = 0;
        waited = 0;
        cycle  = 0;
        while (pos < exp_bytes.size() && waited < TIMEOUT_CYCLES)
        begin
            lane_ready <= ready_pattern[cycle % ready_pattern.size()];
            cycle++;
            @(posedge clk);
            waited++;
            if (lane_valid != '0 && lane_ready)
            begin
                cnt      = (exp_bytes.size() - pos < lanes) ? exp_bytes.size() - pos : lanes;
                exp_mask = lane_mask_t'((1 << cnt) - 1);
                exp_data = '0;
                keep     = '0;
                for (int i = 0; i < cnt; i++)
                begin
                    exp_data[8*i +: 8] = exp_bytes[pos + i];  // lane i carries byte j*N+i
                    keep[8*i +: 8]     = 8'hFF;
                end
                check_value(name, "lane_valid", exp_mask, lane_valid);
                check_value(name, "lane_data", exp_data, lane_data & keep);
                check_value(name, "lane_last", pos + cnt == exp_bytes.size(), lane_last);
                pos    += cnt;
                waited = 0;
            end
        end
        lane_ready <= 1'b1;
        if (pos < exp_bytes.size())
        begin
            $display("Timeout in test %s: only %0d of %0d bytes came out on the lanes",
                     name, pos, exp_bytes.size());
            timeouts++;
        end
    endtask

    initial
    begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        in_data    = '0;
        in_valid   = 1'b0;
        lane_count = lane_count_t'(1);
        lane_ready = 1'b0;
        errors     = 0;
        timeouts   = 0;
        tests[0] = '{"short_1lane", 8'h05, 16'hA5C3, 3'd1, 1'b0, 1'b0};
        tests[1] = '{"long13_4lane", 8'h39, 16'd13, 3'd4, 1'b0, 1'b0};
        tests[2] = '{"long9_2lane", 8'h29, 16'd9, 3'd2, 1'b0, 1'b0};
        tests[3] = '{"long10_3lane", 8'h7E, 16'd10, 3'd3, 1'b0, 1'b0};  // vc 1
        tests[4] = '{"long0_2lane", 8'h19, 16'd0, 3'd2, 1'b0, 1'b0};
        tests[5] = '{"long13_stall", 8'h39, 16'd13, 3'd4, 1'b1, 1'b1};

        @(posedge clk);
        repeat (15)
        begin
            @(posedge clk);
            check_value("reset", "lane_valid", '0, lane_valid);
            check_value("reset", "lane_last", '0, lane_last);
            check_value("reset", "in_ready", '0, in_ready);
        end
        rst_n <= 1'b1;
        @(posedge clk);
        check_value("after_reset", "lane_valid", '0, lane_valid);
        check_value("after_reset", "lane_last", '0, lane_last);
        check_value("after_reset", "in_ready", '0, in_ready);

        for (int t = 0; t < NUM_TESTS; t++)
        begin
            build_packet(tests[t]);
            lane_count <= tests[t].lanes;  // pipeline is empty here
            @(posedge clk);
            fork
                drive_words(tests[t].name);
                collect_beats(tests[t].name, int'(tests[t].lanes));
            join
        end

        repeat (4) @(posedge clk);
        check_value("idle", "lane_valid", '0, lane_valid);
        $display("Errors: %0d, property failures: %0d, timeouts: %0d",
                 errors, DUT.u_props.fail_count, timeouts);
        if (errors == 0 && timeouts == 0 && DUT.u_props.fail_count == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule
